//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
    --top-module tb_trc_operand_tracer -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/trc_compressed_decoder.sv
`timescale 1ns/100ps
`include "trc_consts.svh"

module trc_compressed_decoder (
    input  trc_pkg::instr_word_t instr_i,
    output trc_pkg::instr_info_t info_o
);

    logic [4:0]            sel;
    logic [`TRC_REG_W-1:0] reg_a;
    logic [`TRC_REG_W-1:0] reg_b;
    logic [`TRC_REG_W-1:0] creg_hi;
    logic [`TRC_REG_W-1:0] creg_lo;

    assign sel     = {instr_i[1:0], instr_i[15:13]};    // quadrant and funct3.
    assign reg_a   = instr_i[11:7];
    assign reg_b   = instr_i[6:2];
    assign creg_hi = `TRC_CREG_BASE + {2'b00, instr_i[9:7]};
    assign creg_lo = `TRC_CREG_BASE + {2'b00, instr_i[4:2]};

    always_comb begin
        info_o       = '0;
        info_o.itype = trc_pkg::BASE;
        case (sel)
            5'b00_000: begin
                info_o.source.rs1      = `TRC_REG_SP;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: creg_lo, rd_used: 1'b1};
            end
            5'b00_010: begin
                info_o.itype           = trc_pkg::LOAD;
                info_o.source.rs1      = creg_hi;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: creg_lo, rd_used: 1'b1};
            end
            5'b00_110: begin
                info_o.itype  = trc_pkg::STORE;
                info_o.source = '{rs1: creg_hi, rs2: creg_lo, rs1_used: 1'b1, rs2_used: 1'b1};
            end
            5'b01_000, 5'b10_000: begin
                info_o.source.rs1      = reg_a;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: reg_a, rd_used: 1'b1};
            end
            5'b01_001: begin
                info_o.itype = trc_pkg::JAL;
                info_o.dest  = '{rd: `TRC_REG_RA, rd_used: 1'b1};
            end
            5'b01_010: begin
                info_o.dest = '{rd: reg_a, rd_used: 1'b1};
            end
            5'b01_011: begin
                // addi16sp when the target is sp, lui otherwise.
                if (reg_a == `TRC_REG_SP) begin
                    info_o.source.rs1      = `TRC_REG_SP;
                    info_o.source.rs1_used = 1'b1;
                end
                info_o.dest = '{rd: reg_a, rd_used: 1'b1};
            end
            5'b01_100: begin
                info_o.source.rs1      = creg_hi;
                info_o.source.rs1_used = 1'b1;
                if (instr_i[11:10] == 2'b11) begin
                    info_o.source.rs2      = creg_lo;    // register-register ALU group.
                    info_o.source.rs2_used = 1'b1;
                end
                info_o.dest = '{rd: creg_hi, rd_used: 1'b1};
            end
            5'b01_101: begin
                info_o.itype = trc_pkg::JAL;
            end
            5'b01_110, 5'b01_111: begin
                info_o.itype           = trc_pkg::BRANCH;
                info_o.source.rs1      = creg_hi;
                info_o.source.rs1_used = 1'b1;
            end
            5'b10_010: begin
                info_o.itype           = trc_pkg::LOAD;
                info_o.source.rs1      = `TRC_REG_SP;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: reg_a, rd_used: 1'b1};
            end
            5'b10_100: begin
                if (reg_b != '0) begin
                    if (instr_i[12]) begin
                        info_o.source.rs1      = reg_a;    // c.add reads its target.
                        info_o.source.rs1_used = 1'b1;
                    end
                    info_o.source.rs2      = reg_b;
                    info_o.source.rs2_used = 1'b1;
                    info_o.dest            = '{rd: reg_a, rd_used: 1'b1};
                end else if (instr_i[12] && instr_i[11:2] == '0) begin
                    info_o.itype = trc_pkg::CSR;    // c.ebreak.
                end else begin
                    info_o.itype           = trc_pkg::JALR;
                    info_o.source.rs1      = reg_a;
                    info_o.source.rs1_used = 1'b1;
                    if (instr_i[12]) begin
                        info_o.dest = '{rd: `TRC_REG_RA, rd_used: 1'b1};
                    end
                end
            end
            5'b10_110: begin
                info_o.itype  = trc_pkg::STORE;
                info_o.source = '{rs1: `TRC_REG_SP, rs2: reg_b, rs1_used: 1'b1, rs2_used: 1'b1};
            end
            default: begin
                info_o.itype = trc_pkg::BASE;
            end
        endcase
    end

endmodule

//--- source/trc_consts.svh
`ifndef TRC_CONSTS_SVH
`define TRC_CONSTS_SVH

`define TRC_INSTR_W     32
`define TRC_REG_W       5

`define TRC_CREG_BASE   5'd8    // compressed register field 0 maps to x8.
`define TRC_REG_SP      5'd2
`define TRC_REG_RA      5'd1

// major opcodes, instruction bits 6 to 2.
`define TRC_OPC_LUI     5'b01101
`define TRC_OPC_AUIPC   5'b00101
`define TRC_OPC_JAL     5'b11011
`define TRC_OPC_JALR    5'b11001
`define TRC_OPC_BRANCH  5'b11000
`define TRC_OPC_LOAD    5'b00000
`define TRC_OPC_STORE   5'b01000
`define TRC_OPC_OPIMM   5'b00100
`define TRC_OPC_OP      5'b01100
`define TRC_OPC_FENCE   5'b00011
`define TRC_OPC_SYSTEM  5'b11100

`endif

//--- source/trc_decode_stage.sv
`timescale 1ns/100ps

module trc_decode_stage (
    input  trc_pkg::instr_word_t instr_i,
    output trc_pkg::instr_info_t info_o
);

    trc_pkg::instr_info_t full_info;
    trc_pkg::instr_info_t comp_info;
    logic                 is_full;

    trc_full_decoder u_full_decoder (
        .instr_i (instr_i),
        .info_o  (full_info)
    );

    trc_compressed_decoder u_compressed_decoder (
        .instr_i (instr_i),
        .info_o  (comp_info)
    );

    // both low bits set marks a 32-bit encoding.
    assign is_full = (instr_i[1:0] == 2'b11);

    assign info_o = is_full ? full_info : comp_info;

endmodule

//--- source/trc_full_decoder.sv
`timescale 1ns/100ps
`include "trc_consts.svh"

module trc_full_decoder (
    input  trc_pkg::instr_word_t instr_i,
    output trc_pkg::instr_info_t info_o
);

    logic [4:0]            opcode;
    logic [2:0]            funct3;
    logic [`TRC_REG_W-1:0] rs1;
    logic [`TRC_REG_W-1:0] rs2;
    logic [`TRC_REG_W-1:0] rd;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    always_comb begin
        info_o       = '0;
        info_o.itype = trc_pkg::BASE;
        case (opcode)
            `TRC_OPC_LUI, `TRC_OPC_AUIPC: begin
                info_o.dest = '{rd: rd, rd_used: 1'b1};
            end
            `TRC_OPC_JAL: begin
                info_o.itype = trc_pkg::JAL;
                info_o.dest  = '{rd: rd, rd_used: 1'b1};
            end
            `TRC_OPC_JALR: begin
                info_o.itype           = trc_pkg::JALR;
                info_o.source.rs1      = rs1;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: rd, rd_used: 1'b1};
            end
            `TRC_OPC_BRANCH, `TRC_OPC_STORE: begin
                info_o.itype  = (opcode == `TRC_OPC_BRANCH) ? trc_pkg::BRANCH : trc_pkg::STORE;
                info_o.source = '{rs1: rs1, rs2: rs2, rs1_used: 1'b1, rs2_used: 1'b1};
            end
            `TRC_OPC_LOAD, `TRC_OPC_OPIMM: begin
                info_o.itype           = (opcode == `TRC_OPC_LOAD) ? trc_pkg::LOAD : trc_pkg::BASE;
                info_o.source.rs1      = rs1;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = '{rd: rd, rd_used: 1'b1};
            end
            `TRC_OPC_OP: begin
                info_o.itype  = instr_i[25] ? trc_pkg::MEXT : trc_pkg::BASE;    // funct7 bit 0.
                info_o.source = '{rs1: rs1, rs2: rs2, rs1_used: 1'b1, rs2_used: 1'b1};
                info_o.dest   = '{rd: rd, rd_used: 1'b1};
            end
            `TRC_OPC_FENCE: begin
                info_o.itype = trc_pkg::CSR;
            end
            `TRC_OPC_SYSTEM: begin
                info_o.itype = trc_pkg::CSR;
                if (funct3 != 3'b000) begin
                    // the immediate forms carry a constant in the rs1 field.
                    if (!funct3[2]) begin
                        info_o.source.rs1      = rs1;
                        info_o.source.rs1_used = 1'b1;
                    end
                    info_o.dest = '{rd: rd, rd_used: 1'b1};
                end
            end
            default: begin
                info_o.itype = trc_pkg::BASE;
            end
        endcase
    end

endmodule

//--- source/trc_operand_tracer.sv
`timescale 1ns/100ps

module trc_operand_tracer (
    input  logic                 s_clk_i,
    input  logic                 arst_n_i,
    input  logic                 instr_valid_i,
    input  trc_pkg::instr_word_t instr_i,
    output logic                 info_valid_o,
    output trc_pkg::instr_info_t info_o
);

    logic                 cap_valid;
    trc_pkg::instr_word_t cap_word;
    trc_pkg::instr_info_t dec_info;

    trc_pipe_stage #(
        .payload_t (trc_pkg::instr_word_t)
    ) u_capture_stage (
        .s_clk_i  (s_clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (instr_valid_i),
        .data_i   (instr_i),
        .valid_o  (cap_valid),
        .data_o   (cap_word)
    );

    trc_decode_stage u_decode_stage (
        .instr_i (cap_word),
        .info_o  (dec_info)
    );

    trc_pipe_stage #(
        .payload_t (trc_pkg::instr_info_t)
    ) u_result_stage (
        .s_clk_i  (s_clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (cap_valid),
        .data_i   (dec_info),
        .valid_o  (info_valid_o),
        .data_o   (info_o)
    );

endmodule

//--- source/trc_pipe_stage.sv
`timescale 1ns/100ps

module trc_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     s_clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_o <= '0;
        end else if (valid_i) begin
            data_o <= data_i;    // idle cycles keep the last payload visible.
        end
    end

    // an upstream stage must never hand over a valid payload with undefined bits.
    a_known_payload : assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i)
        valid_i |-> !$isunknown(data_i)
    ) else $error("trc_pipe_stage: unknown bits in a valid payload");

endmodule

//--- source/trc_pkg.sv
`include "trc_consts.svh"

package trc_pkg;

    typedef enum logic [3:0] {
        BASE,
        MEXT,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        CSR
    } itype_e;

    typedef logic [`TRC_INSTR_W-1:0] instr_word_t;

    // a register field whose used flag is clear holds zero.
    typedef struct packed {
        logic [`TRC_REG_W-1:0] rs1;
        logic [`TRC_REG_W-1:0] rs2;
        logic                  rs1_used;
        logic                  rs2_used;
    } source_t;

    typedef struct packed {
        logic [`TRC_REG_W-1:0] rd;
        logic                  rd_used;
    } dest_t;

    typedef struct packed {
        source_t source;
        dest_t   dest;
        itype_e  itype;
    } instr_info_t;

endpackage

//--- verif/tb_trc_operand_tracer.sv
`timescale 1ns/100ps
`include "trc_consts.svh"

module tb_trc_operand_tracer;

    localparam int RESET_CYCLES = 10;
    localparam int FULL_N       = 400;
    localparam int COMP_N       = 400;
    localparam int MIX_N        = 300;
    localparam int MAX_GAP      = 3;
    localparam int STREAM_N     = 40;
    localparam int DRAIN        = 8;
    localparam int LIMIT_CYCLES = 2 * RESET_CYCLES + FULL_N + COMP_N + MIX_N * (MAX_GAP + 1)
                                  + STREAM_N + 5 * DRAIN + 100;
    localparam logic [4:0] OPCODES [11] = '{`TRC_OPC_LUI, `TRC_OPC_AUIPC, `TRC_OPC_JAL,
        `TRC_OPC_JALR, `TRC_OPC_BRANCH, `TRC_OPC_LOAD, `TRC_OPC_STORE, `TRC_OPC_OPIMM,
        `TRC_OPC_OP, `TRC_OPC_FENCE, `TRC_OPC_SYSTEM};

    logic                 s_clk_i = 1'b0;
    logic                 arst_n_i;
    logic                 instr_valid_i;
    trc_pkg::instr_word_t instr_i;
    logic                 info_valid_o;
    trc_pkg::instr_info_t info_o;

    trc_pkg::instr_info_t exp_q[$];
    trc_pkg::instr_info_t last_info;
    logic [1:0]           valid_pipe;
    string                test_name = "power_on_reset";
    int                   err_start = 0;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests = 0;
    int                   cycles = 0;

    trc_operand_tracer UUT (
        .s_clk_i       (s_clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .info_valid_o  (info_valid_o),
        .info_o        (info_o)
    );

    always #2 s_clk_i = ~s_clk_i;

    always @(posedge s_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYCLES) begin
            $display("error: the run timed out after %0d cycles in %s", cycles, test_name);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], instr_valid_i};    // two cycles of latency.
        end
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // used is {rs1_used, rs2_used, rd_used}; an unused field reads as zero.
    function automatic trc_pkg::instr_info_t pack_info(trc_pkg::itype_e t, logic [4:0] s1,
                                                       logic [4:0] s2, logic [4:0] d,
                                                       logic [2:0] used);
        trc_pkg::instr_info_t info;
        info = '0;
        info.itype = t;
        info.source = '{rs1: used[2] ? s1 : 5'd0, rs2: used[1] ? s2 : 5'd0,
                        rs1_used: used[2], rs2_used: used[1]};
        info.dest = '{rd: used[0] ? d : 5'd0, rd_used: used[0]};
        return info;
    endfunction

    function automatic trc_pkg::instr_info_t full_model(trc_pkg::instr_word_t w);
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        trc_pkg::instr_info_t r;
        rs1 = w[19:15];
        rs2 = w[24:20];
        rd  = w[11:7];
        r   = pack_info(trc_pkg::BASE, rs1, rs2, rd, 3'b000);
        case (w[6:2])
            `TRC_OPC_LUI, `TRC_OPC_AUIPC: r = pack_info(trc_pkg::BASE, rs1, rs2, rd, 3'b001);
            `TRC_OPC_JAL: r = pack_info(trc_pkg::JAL, rs1, rs2, rd, 3'b001);
            `TRC_OPC_JALR: r = pack_info(trc_pkg::JALR, rs1, rs2, rd, 3'b101);
            `TRC_OPC_BRANCH: r = pack_info(trc_pkg::BRANCH, rs1, rs2, rd, 3'b110);
            `TRC_OPC_LOAD: r = pack_info(trc_pkg::LOAD, rs1, rs2, rd, 3'b101);
            `TRC_OPC_STORE: r = pack_info(trc_pkg::STORE, rs1, rs2, rd, 3'b110);
            `TRC_OPC_OPIMM: r = pack_info(trc_pkg::BASE, rs1, rs2, rd, 3'b101);
            `TRC_OPC_OP: r = pack_info(w[25] ? trc_pkg::MEXT : trc_pkg::BASE, rs1, rs2, rd, 3'b111);
            `TRC_OPC_FENCE: r = pack_info(trc_pkg::CSR, rs1, rs2, rd, 3'b000);
            `TRC_OPC_SYSTEM: begin
                if (w[14:12] != 3'b000) begin
                    r = pack_info(trc_pkg::CSR, rs1, rs2, rd, {~w[14], 2'b01});
                end else begin
                    r = pack_info(trc_pkg::CSR, rs1, rs2, rd, 3'b000);
                end
            end
            default: r = pack_info(trc_pkg::BASE, rs1, rs2, rd, 3'b000);
        endcase
        return r;
    endfunction

    function automatic trc_pkg::instr_info_t compressed_model(trc_pkg::instr_word_t w);
        logic [4:0] ra_f;
        logic [4:0] rb_f;
        logic [4:0] ch;
        logic [4:0] cl;
        trc_pkg::instr_info_t r;
        ra_f = w[11:7];
        rb_f = w[6:2];
        ch   = `TRC_CREG_BASE + 5'(w[9:7]);
        cl   = `TRC_CREG_BASE + 5'(w[4:2]);
        r    = pack_info(trc_pkg::BASE, ra_f, rb_f, ra_f, 3'b000);
        case ({w[1:0], w[15:13]})
            5'b00_000: r = pack_info(trc_pkg::BASE, `TRC_REG_SP, rb_f, cl, 3'b101);
            5'b00_010: r = pack_info(trc_pkg::LOAD, ch, rb_f, cl, 3'b101);
            5'b00_110: r = pack_info(trc_pkg::STORE, ch, cl, ra_f, 3'b110);
            5'b01_000, 5'b10_000: r = pack_info(trc_pkg::BASE, ra_f, rb_f, ra_f, 3'b101);
            5'b01_001: r = pack_info(trc_pkg::JAL, ra_f, rb_f, `TRC_REG_RA, 3'b001);
            5'b01_010: r = pack_info(trc_pkg::BASE, ra_f, rb_f, ra_f, 3'b001);
            5'b01_011: r = pack_info(trc_pkg::BASE, `TRC_REG_SP, rb_f, ra_f,
                                     {ra_f == `TRC_REG_SP, 2'b01});
            5'b01_100: r = pack_info(trc_pkg::BASE, ch, cl, ch, {1'b1, w[11:10] == 2'b11, 1'b1});
            5'b01_101: r = pack_info(trc_pkg::JAL, ra_f, rb_f, ra_f, 3'b000);
            5'b01_110, 5'b01_111: r = pack_info(trc_pkg::BRANCH, ch, rb_f, ra_f, 3'b100);
            5'b10_010: r = pack_info(trc_pkg::LOAD, `TRC_REG_SP, rb_f, ra_f, 3'b101);
            5'b10_100: begin
                if (rb_f != 5'd0) begin
                    r = pack_info(trc_pkg::BASE, ra_f, rb_f, ra_f, {w[12], 2'b11});
                end else if (w[12] && w[11:2] == 10'd0) begin
                    r = pack_info(trc_pkg::CSR, ra_f, rb_f, ra_f, 3'b000);    // ebreak.
                end else begin
                    r = pack_info(trc_pkg::JALR, ra_f, rb_f, `TRC_REG_RA, {2'b10, w[12]});
                end
            end
            5'b10_110: r = pack_info(trc_pkg::STORE, `TRC_REG_SP, rb_f, ra_f, 3'b110);
            default: r = pack_info(trc_pkg::BASE, ra_f, rb_f, ra_f, 3'b000);
        endcase
        return r;
    endfunction

    function automatic trc_pkg::instr_word_t random_full(int idx);
        trc_pkg::instr_word_t w;
        w = $urandom;
        if (idx % 4 != 3) begin
            w[6:2] = OPCODES[idx % 11];    // one word in four keeps a random opcode.
        end
        w[1:0] = 2'b11;
        return w;
    endfunction

    function automatic trc_pkg::instr_word_t random_compressed();
        trc_pkg::instr_word_t w;
        w = $urandom;
        w[1:0] = 2'($urandom_range(0, 2));
        case ($urandom_range(0, 7))
            0: w[6:2] = 5'd0;
            1: w[15:0] = 16'h9002;
            2: {w[15:13], w[6:2], w[1:0]} = 10'b100_00000_10;
            3: {w[15:13], w[1:0]} = 5'b100_10;
            default: ;
        endcase
        return w;
    endfunction

    always @(negedge s_clk_i) begin : output_monitor
        trc_pkg::instr_info_t expected;
        if (!arst_n_i) begin
            last_info = '0;
        end else begin
            check_value("valid", 32'(valid_pipe[1]), 32'(info_valid_o));
            if (info_valid_o && exp_q.size() == 0) begin
                $display("error: %s gave a result with no word pending", test_name);
                errors++;
            end else if (info_valid_o) begin
                expected = exp_q.pop_front();
                check_value("info", 32'(expected), 32'(info_o));
                last_info = expected;
            end else begin
                check_value("held info", 32'(last_info), 32'(info_o));
            end
        end
    end

    task automatic drive(logic valid, trc_pkg::instr_word_t word);
        @(posedge s_clk_i);
        instr_valid_i <= valid;
        instr_i       <= word;
        if (valid) begin
            exp_q.push_back((word[1:0] == 2'b11) ? full_model(word) : compressed_model(word));
        end
    endtask

    task automatic apply_reset(int n);
        @(posedge s_clk_i);
        arst_n_i      <= 1'b0;
        instr_valid_i <= 1'b0;
        exp_q.delete();    // words in flight are lost.
        repeat (n) @(posedge s_clk_i);
        @(negedge s_clk_i);
        check_value("valid in reset", 32'd0, 32'(info_valid_o));
        @(posedge s_clk_i);
        arst_n_i <= 1'b1;
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        drive(1'b0, $urandom);
        while (exp_q.size() != 0) begin
            @(posedge s_clk_i);
        end
        repeat (3) @(posedge s_clk_i);
        tests++;
        $display("test %s finished with %0d errors", test_name, errors - err_start);
    endtask

    initial begin
        void'($urandom(60231));
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        apply_reset(RESET_CYCLES);

        start_test("reset_state");
        repeat (3) @(negedge s_clk_i);
        check_value("valid after reset", 32'd0, 32'(info_valid_o));
        check_value("info after reset", 32'd0, 32'(info_o));
        finish_test();

        start_test("full_width");
        for (int i = 0; i < FULL_N; i++) drive(1'b1, random_full(i));
        finish_test();

        start_test("compressed");
        for (int i = 0; i < COMP_N; i++) drive(1'b1, random_compressed());
        finish_test();

        start_test("mixed_gaps");
        for (int i = 0; i < MIX_N; i++) begin
            repeat ($urandom_range(0, MAX_GAP)) drive(1'b0, $urandom);
            drive(1'b1, $urandom_range(0, 1) ? random_full(i) : random_compressed());
        end
        finish_test();

        start_test("mid_reset");
        for (int i = 0; i < STREAM_N / 2; i++) drive(1'b1, random_full(i));
        apply_reset(3);
        for (int i = 0; i < STREAM_N / 2; i++) drive(1'b1, random_compressed());
        finish_test();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/trc_pkg.sv
source/trc_pipe_stage.sv
source/trc_full_decoder.sv
source/trc_compressed_decoder.sv
source/trc_decode_stage.sv
source/trc_operand_tracer.sv
verif/tb_trc_operand_tracer.sv
